// File: Bender.yml
package:
  name: div_top

sources:
  - div_pkg.sv
  - div_operand_if.sv
  - div_result_if.sv
  - div_operand_skid.sv
  - div_pipeline_ctrl.sv
  - div_nonrestoring_core.sv
  - div_result_fifo.sv
  - div_top.sv
  - target: test
    files:
      - tb_div_top.sv

// File: div_nonrestoring_core.sv
`default_nettype none

module div_nonrestoring_core import div_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	div_operand_if.sink  in,
	div_result_if.source out
);

	logic        advance;
	stage_mask_t stage_valid;

	div_pipeline_ctrl i_ctrl (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in.valid),
		.out_ready   (out.ready),
		.advance     (advance),
		.stage_valid (stage_valid)
	);

	assign in.ready  = advance;
	assign out.valid = stage_valid[div_stages-1];

	// --------------------
	// iteration stages
	// --------------------
	remainder_t it_rem  [quotient_w];
	quotient_t  it_quo  [quotient_w];
	divisor_t   it_div  [quotient_w];
	logic       it_sign [quotient_w];
	tag_t       it_tag  [quotient_w];

	remainder_t nx_rem [quotient_w];
	quotient_t  nx_quo [quotient_w];

	always_comb begin
		remainder_t           src_rem;
		quotient_t            src_quo;
		divisor_t             src_div;
		logic [remainder_w:0] shift_rem;
		logic [remainder_w:0] ext_div;
		logic [remainder_w:0] sum;
		logic                 q_bit;
		for (int i = 0; i < quotient_w; i++) begin
			if (i == 0) begin
				// stage 0 sign extends dividend into joint register
				src_rem = {remainder_w{in.dividend[dividend_w-1]}};
				src_quo = in.dividend;
				src_div = in.divisor;
			end else begin
				src_rem = it_rem[i-1];
				src_quo = it_quo[i-1];
				src_div = it_div[i-1];
			end
			// joint shift, top quotient bit moves into remainder
			shift_rem = {src_rem, src_quo[quotient_w-1]};
			ext_div   = {src_div[divisor_w-1], src_div};
			if (shift_rem[remainder_w] == src_div[divisor_w-1]) begin
				sum   = shift_rem - ext_div;
				q_bit = 1'b1;
			end else begin
				sum   = shift_rem + ext_div;
				q_bit = 1'b0;
			end
			nx_rem[i] = sum[remainder_w-1:0];
			nx_quo[i] = {src_quo[quotient_w-2:0], q_bit};
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			it_tag[0]  <= in.tag;
			it_div[0]  <= in.divisor;
			it_sign[0] <= in.dividend[dividend_w-1];
			for (int i = 1; i < quotient_w; i++) begin
				it_tag[i]  <= it_tag[i-1];
				it_div[i]  <= it_div[i-1];
				it_sign[i] <= it_sign[i-1];
			end
			for (int i = 0; i < quotient_w; i++) begin
				it_rem[i] <= nx_rem[i];
				it_quo[i] <= nx_quo[i];
			end
		end
	end

	// --------------------
	// correction stage
	// --------------------
	remainder_t last_rem;
	quotient_t  last_quo;
	divisor_t   last_div;
	divisor_t   neg_div;
	logic       last_sign;
	logic       fix_up;
	logic       fix_down;

	tag_t       res_tag;
	quotient_t  res_quo;
	remainder_t res_rem;

	assign last_rem  = it_rem[quotient_w-1];
	assign last_div  = it_div[quotient_w-1];
	assign last_sign = it_sign[quotient_w-1];
	assign neg_div   = -last_div;
	// final digit is always one
	assign last_quo  = {it_quo[quotient_w-1][quotient_w-2:0], 1'b1};

	always_comb begin
		fix_up   = 1'b0;
		fix_down = 1'b0;
		if (last_rem == remainder_t'(last_div)) begin
			fix_up = 1'b1;
		end else if (last_rem == remainder_t'(neg_div)) begin
			fix_down = 1'b1;
		end else if (last_rem != '0 && last_rem[remainder_w-1] != last_sign) begin
			// remainder must follow the dividend sign
			if (last_rem[remainder_w-1] == last_div[divisor_w-1]) begin
				fix_up = 1'b1;
			end else begin
				fix_down = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			res_tag <= it_tag[quotient_w-1];
			if (fix_up) begin
				res_quo <= last_quo + quotient_t'(1);
				res_rem <= last_rem - remainder_t'(last_div);
			end else if (fix_down) begin
				res_quo <= last_quo - quotient_t'(1);
				res_rem <= last_rem + remainder_t'(last_div);
			end else begin
				res_quo <= last_quo;
				res_rem <= last_rem;
			end
		end
	end

	assign out.tag       = res_tag;
	assign out.quotient  = res_quo;
	assign out.remainder = res_rem;

endmodule

`default_nettype wire

// File: div_operand_if.sv
`default_nettype none

// operand stream into the divider core
interface div_operand_if import div_pkg::*; ();

	tag_t      tag;
	dividend_t dividend;
	divisor_t  divisor;
	logic      valid;
	logic      ready;

	modport source (
		output tag,
		output dividend,
		output divisor,
		output valid,
		input  ready
	);

	modport sink (
		input  tag,
		input  dividend,
		input  divisor,
		input  valid,
		output ready
	);

endinterface

`default_nettype wire

// File: div_operand_skid.sv
`default_nettype none

module div_operand_skid import div_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  tag_t                 in_tag,
	input  dividend_t            in_dividend,
	input  divisor_t             in_divisor,
	input  logic                 in_valid,
	output logic                 in_ready,
	div_operand_if.source        out
);

	logic      main_valid;
	tag_t      main_tag;
	dividend_t main_dividend;
	divisor_t  main_divisor;

	logic      ovf_valid;
	tag_t      ovf_tag;
	dividend_t ovf_dividend;
	divisor_t  ovf_divisor;

	logic in_take;
	logic out_take;
	logic main_free;

	// ready comes from a flop, never from downstream
	assign in_ready  = ~ovf_valid;
	assign in_take   = in_valid & in_ready;
	assign out_take  = main_valid & out.ready;
	assign main_free = ~main_valid | out_take;

	always_ff @(posedge clk) begin
		if (reset) begin
			main_valid <= 1'b0;
			ovf_valid  <= 1'b0;
		end else begin
			if (main_free) begin
				main_valid <= ovf_valid | in_take;
			end
			if (out_take) begin
				ovf_valid <= 1'b0;
			end else if (main_valid && in_take) begin
				// stalled, park the extra item
				ovf_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (main_free) begin
			if (ovf_valid) begin
				main_tag      <= ovf_tag;
				main_dividend <= ovf_dividend;
				main_divisor  <= ovf_divisor;
			end else begin
				main_tag      <= in_tag;
				main_dividend <= in_dividend;
				main_divisor  <= in_divisor;
			end
		end
		if (!ovf_valid) begin
			ovf_tag      <= in_tag;
			ovf_dividend <= in_dividend;
			ovf_divisor  <= in_divisor;
		end
	end

	assign out.valid    = main_valid;
	assign out.tag      = main_tag;
	assign out.dividend = main_dividend;
	assign out.divisor  = main_divisor;

endmodule

`default_nettype wire

// File: div_pipeline_ctrl.sv
`default_nettype none

module div_pipeline_ctrl import div_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        in_valid,
	input  logic        out_ready,
	output logic        advance,
	output stage_mask_t stage_valid
);

	logic last_valid;

	assign last_valid = stage_valid[div_stages-1];

	// whole pipe moves together; it only halts when the
	// last stage holds a result nobody takes
	assign advance = ~last_valid | out_ready;

	// --------------------
	// valid shift register
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			stage_valid <= '0;
		end else if (advance) begin
			stage_valid <= {stage_valid[div_stages-2:0], in_valid};
		end
	end

endmodule

`default_nettype wire

// File: div_pkg.sv
`default_nettype none

package div_pkg;

	// --------------------
	// operand and result widths
	// --------------------
	localparam int dividend_w  = 16;
	localparam int divisor_w   = 8;
	localparam int quotient_w  = dividend_w;
	localparam int remainder_w = divisor_w;
	localparam int tag_w       = 4;

	// one iteration per quotient bit, then the correction stage
	localparam int div_stages = quotient_w + 1;

	// result buffer
	localparam int fifo_depth = 4;
	localparam int fifo_ptr_w = $clog2(fifo_depth);

	// --------------------
	// vector types
	// --------------------
	typedef logic signed [dividend_w-1:0] dividend_t;
	typedef logic signed [divisor_w-1:0]  divisor_t;
	typedef logic signed [quotient_w-1:0] quotient_t;
	typedef logic [remainder_w-1:0]       remainder_t;
	typedef logic [tag_w-1:0]             tag_t;
	typedef logic [div_stages-1:0]        stage_mask_t;

	// fifo bookkeeping, count needs one bit more than a pointer
	typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;
	typedef logic [fifo_ptr_w:0]   fifo_count_t;

endpackage

`default_nettype wire

// File: div_result_fifo.sv
`default_nettype none

module div_result_fifo import div_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	div_result_if.sink   in,
	output tag_t         out_tag,
	output quotient_t    out_quotient,
	output remainder_t   out_remainder,
	output logic         out_valid,
	input  logic         out_ready
);

	tag_t       mem_tag [fifo_depth];
	quotient_t  mem_quo [fifo_depth];
	remainder_t mem_rem [fifo_depth];

	fifo_ptr_t   wr_ptr;
	fifo_ptr_t   rd_ptr;
	fifo_count_t count;

	logic wr_en;
	logic rd_en;

	assign in.ready = (count != fifo_count_t'(fifo_depth));
	assign wr_en    = in.valid & in.ready;
	assign rd_en    = out_valid & out_ready;

	// --------------------
	// pointers and occupancy
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == fifo_ptr_t'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == fifo_ptr_t'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_tag[wr_ptr] <= in.tag;
			mem_quo[wr_ptr] <= in.quotient;
			mem_rem[wr_ptr] <= in.remainder;
		end
	end

	// head entry straight from the storage flops
	assign out_valid     = (count != '0);
	assign out_tag       = mem_tag[rd_ptr];
	assign out_quotient  = mem_quo[rd_ptr];
	assign out_remainder = mem_rem[rd_ptr];

endmodule

`default_nettype wire

// File: div_result_if.sv
`default_nettype none

// result stream out of the divider core
interface div_result_if import div_pkg::*; ();

	tag_t       tag;
	quotient_t  quotient;
	remainder_t remainder;
	logic       valid;
	logic       ready;

	modport source (
		output tag,
		output quotient,
		output remainder,
		output valid,
		input  ready
	);

	modport sink (
		input  tag,
		input  quotient,
		input  remainder,
		input  valid,
		output ready
	);

endinterface

`default_nettype wire

// File: div_top.f
div_pkg.sv
div_operand_if.sv
div_result_if.sv
div_operand_skid.sv
div_pipeline_ctrl.sv
div_nonrestoring_core.sv
div_result_fifo.sv
div_top.sv
tb_div_top.sv

// File: div_top.sv
`default_nettype none

module div_top import div_pkg::*; (
	input  logic       clk,
	input  logic       reset,

	input  tag_t       s_tag,
	input  dividend_t  s_dividend,
	input  divisor_t   s_divisor,
	input  logic       s_valid,
	output logic       s_ready,

	output tag_t       m_tag,
	output quotient_t  m_quotient,
	output remainder_t m_remainder,
	output logic       m_valid,
	input  logic       m_ready
);

	div_operand_if operand_bus ();
	div_result_if  result_bus ();

	// --------------------
	// input skid
	// --------------------
	div_operand_skid i_skid (
		.clk         (clk),
		.reset       (reset),
		.in_tag      (s_tag),
		.in_dividend (s_dividend),
		.in_divisor  (s_divisor),
		.in_valid    (s_valid),
		.in_ready    (s_ready),
		.out         (operand_bus)
	);

	// divider pipeline
	div_nonrestoring_core i_core (
		.clk   (clk),
		.reset (reset),
		.in    (operand_bus),
		.out   (result_bus)
	);

	// --------------------
	// output buffer
	// --------------------
	div_result_fifo i_fifo (
		.clk           (clk),
		.reset         (reset),
		.in            (result_bus),
		.out_tag       (m_tag),
		.out_quotient  (m_quotient),
		.out_remainder (m_remainder),
		.out_valid     (m_valid),
		.out_ready     (m_ready)
	);

endmodule

`default_nettype wire

// File: tb_div_top.sv
`default_nettype none

module tb_div_top import div_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// input transfer edge to output transfer edge, output always ready
	localparam int first_latency = 1 + div_stages + 1;

	logic       clk = 1'b0;
	logic       reset;
	tag_t       s_tag;
	dividend_t  s_dividend;
	divisor_t   s_divisor;
	logic       s_valid;
	logic       s_ready;
	tag_t       m_tag;
	quotient_t  m_quotient;
	remainder_t m_remainder;
	logic       m_valid;
	logic       m_ready;

	string      tab_name [$];
	dividend_t  tab_dvd  [$];
	divisor_t   tab_dvs  [$];
	quotient_t  tab_quo  [$];
	remainder_t tab_rem  [$];

	int errors      = 0;
	int received    = 0;
	int cycle_count = 0;
	int in_cycle    = -1;
	int seed        = 64;

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	div_top i_dut (
		.clk         (clk),
		.reset       (reset),
		.s_tag       (s_tag),
		.s_dividend  (s_dividend),
		.s_divisor   (s_divisor),
		.s_valid     (s_valid),
		.s_ready     (s_ready),
		.m_tag       (m_tag),
		.m_quotient  (m_quotient),
		.m_remainder (m_remainder),
		.m_valid     (m_valid),
		.m_ready     (m_ready)
	);

	task automatic add_entry(input string name, input int dvd, input int dvs,
		input int quo, input int rem);
		tab_name.push_back(name);
		tab_dvd.push_back(dividend_t'(dvd));
		tab_dvs.push_back(divisor_t'(dvs));
		tab_quo.push_back(quotient_t'(quo));
		tab_rem.push_back(remainder_t'(rem));
	endtask

	task automatic check_value(input string test, input string field, input int expected,
		input int actual);
		if (expected != actual) begin
			errors++;
			$display("error %s %s: expected %0d, got %0d", test, field, expected, actual);
		end
	endtask

	// --------------------
	// stimulus table
	// --------------------
	// name, dividend, divisor, quotient toward zero, remainder
	task automatic build_table();
		add_entry("pos_pos", 100, 7, 14, 2);
		add_entry("neg_pos", -100, 7, -14, -2);
		add_entry("pos_neg", 100, -7, -14, 2);
		add_entry("neg_neg", -100, -7, 14, -2);
		add_entry("exact_pos_pos", 84, 7, 12, 0);
		add_entry("exact_neg_pos", -84, 7, -12, 0);
		add_entry("exact_pos_neg", 84, -7, -12, 0);
		add_entry("exact_neg_neg", -84, -7, 12, 0);
		add_entry("zero_pos", 0, 5, 0, 0);
		add_entry("zero_neg", 0, -5, 0, 0);
		add_entry("small_pos_pos", 3, 10, 0, 3);
		add_entry("small_neg_pos", -3, 10, 0, -3);
		add_entry("small_pos_neg", 3, -10, 0, 3);
		add_entry("small_neg_neg", -3, -10, 0, -3);
		add_entry("max_by_min", 32767, -128, -255, 127);
		add_entry("min_by_max", -32768, 127, -258, -2);
		add_entry("max_by_one", 32767, 1, 32767, 0);
		add_entry("min_by_one", -32768, 1, -32768, 0);
		add_entry("min_by_min", -32768, -128, 256, 0);
		add_entry("max_by_max", 32767, 127, 258, 1);
		add_entry("one_by_neg_one", 1, -1, -1, 0);
		add_entry("big_pos_neg", 12345, -99, -124, 69);
		add_entry("big_neg_pos", -12345, 99, -124, -69);
		add_entry("half_neg", -7, 2, -3, -1);
	endtask

	// one pass over the table, ready is a flop output and stable at the falling edge
	task automatic drive_entries();
		for (int i = 0; i < tab_name.size(); i++) begin
			@(negedge clk);
			s_valid    = 1'b1;
			s_tag      = tag_t'(i % 16);
			s_dividend = tab_dvd[i];
			s_divisor  = tab_dvs[i];
			while (!s_ready) begin
				@(negedge clk);
			end
			if (in_cycle < 0) begin
				in_cycle = cycle_count + 1;
			end
		end
		@(negedge clk);
		s_valid = 1'b0;
	endtask

	initial begin
		reset      = 1'b1;
		s_valid    = 1'b0;
		s_tag      = '0;
		s_dividend = '0;
		s_divisor  = '0;
		m_ready    = 1'b0;
		build_table();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value("after_reset", "m_valid", 0, int'(m_valid));
		check_value("after_reset", "s_ready", 1, int'(s_ready));
		// phase one then phase two
		drive_entries();
		wait (received >= tab_name.size());
		drive_entries();
		wait (received >= 2 * tab_name.size());
		// give a duplicate time to show up
		repeat (div_stages + 4) @(negedge clk);
		check_value("all", "result count", 2 * tab_name.size(), received);
		$display("errors: %0d, results: %0d of %0d", errors, received, 2 * tab_name.size());
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// --------------------
	// result receiver
	// --------------------
	initial begin : receive_results
		int idx;
		int rnd;
		@(negedge reset);
		forever begin
			@(negedge clk);
			rnd = $random(seed);
			if (received < tab_name.size()) begin
				m_ready = 1'b1;
			end else begin
				m_ready = rnd[0];
			end
			if (m_valid && m_ready) begin
				if (received >= 2 * tab_name.size()) begin
					errors++;
					$display("extra result with tag %0d after the last entry", m_tag);
				end else begin
					idx = received % tab_name.size();
					if (received == 0) begin
						check_value("first_result", "latency", first_latency,
							cycle_count + 1 - in_cycle);
					end
					check_value(tab_name[idx], "tag", idx % 16, int'(m_tag));
					check_value(tab_name[idx], "quotient", int'(tab_quo[idx]),
						int'(m_quotient));
					check_value(tab_name[idx], "remainder", int'($signed(tab_rem[idx])),
						int'($signed(m_remainder)));
				end
				received++;
			end
		end
	end

	// watchdog
	initial begin : watchdog
		longint limit_ns;
		@(negedge reset);
		limit_ns = longint'(tab_name.size()) * (div_stages + 8) * 2 * 100;
		#(limit_ns);
		$display("timeout: results stopped arriving, %0d of %0d received, errors: %0d",
			received, 2 * tab_name.size(), errors);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
